// File: dv/mips_pipeline_sva.sv
`default_nettype none

module mips_pipeline_sva (
    input logic i_clk,
    input logic i_reset,
    input logic i_stall,
    input logic i_flush
);

    int assert_failures = 0;   // Failed checks so far

    //////////////////////////////
    // Stall
    // The bubble clears the load from execute
    stall_single: assert property (@(posedge i_clk) disable iff (i_reset)
        i_stall |=> !i_stall)
        else begin
            assert_failures++;
            $error("stall held for more than one cycle");
        end

    //////////////////////////////
    // Flush
    // EX/MEM loses the branch, so the redirect fires once
    flush_single: assert property (@(posedge i_clk) disable iff (i_reset)
        i_flush |=> !i_flush)
        else begin
            assert_failures++;
            $error("flush held for more than one cycle");
        end

    flush_no_stall: assert property (@(posedge i_clk) disable iff (i_reset)
        i_flush |=> !i_stall)   // ID/EX holds a bubble after a flush
        else begin
            assert_failures++;
            $error("stall raised right after a flush");
        end

endmodule

bind pipe_control mips_pipeline_sva mips_pipeline_sva_i (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_stall (o_stall),
    .i_flush (o_flush)
);

`default_nettype wire

// File: dv/mips_pipeline_tb.sv
`default_nettype none

module mips_pipeline_tb import mips_isa_pkg::*; ();

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int N_PROG     = 5;
    localparam int MAX_WORDS  = 24;
    localparam int MAX_CHECKS = 10;

    logic                clk;
    logic                reset;
    logic                imem_we;
    logic [IMEM_AW-1:0]  imem_addr;
    word_t               imem_data;
    reg_addr_t           dbg_addr;
    word_t               dbg_data;
    word_t               pc;

    // Program table and expected registers
    word_t     prog_words [N_PROG][MAX_WORDS];
    int        prog_len   [N_PROG];
    word_t     halt_pc    [N_PROG];
    reg_addr_t exp_reg    [N_PROG][MAX_CHECKS];
    word_t     exp_val    [N_PROG][MAX_CHECKS];
    int        exp_cnt    [N_PROG];

    word_t rng_state;
    int    cycle_count;
    int    cycle_limit;
    int    reg_errors;
    int    pc_errors;

    mips_pipeline_top #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) mips_pipeline_top_i (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_imem_we   (imem_we),
        .i_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .i_dbg_addr  (dbg_addr),
        .o_dbg_data  (dbg_data),
        .o_pc        (pc)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: halt loop or register reads not done in %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    //////////////////////////////
    // Reference rules
    function automatic word_t xorshift32();
        word_t x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [15:0] rand16();
        word_t x;
        x = xorshift32();
        return x[15:0];
    endfunction

    function automatic word_t sext16(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t zext16(logic [15:0] v);
        return {16'h0000, v};
    endfunction

    // Sign bits decide first, equal signs compare as magnitudes
    function automatic word_t slt_ref(word_t a, word_t b);
        if (a[31] != b[31]) begin
            return {31'd0, a[31]};
        end
        return (a < b) ? 32'd1 : 32'd0;
    endfunction

    function automatic word_t r_word(funct_e fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt,
                                     logic [4:0] sh);
        return {op_rtype, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t i_word(opcode_e op, reg_addr_t rt, reg_addr_t rs,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    //////////////////////////////
    // Table building
    task automatic add_word(int p, word_t w);
        prog_words[p][prog_len[p]] = w;
        prog_len[p] = prog_len[p] + 1;
    endtask

    task automatic add_expect(int p, reg_addr_t r, word_t v);
        exp_reg[p][exp_cnt[p]] = r;
        exp_val[p][exp_cnt[p]] = v;
        exp_cnt[p] = exp_cnt[p] + 1;
    endtask

    task automatic load_const(int p, reg_addr_t rd, word_t v);
        add_word(p, i_word(op_lui, rd, 5'd0, v[31:16]));
        add_word(p, i_word(op_ori, rd, rd, v[15:0]));
    endtask

    // Branch-to-self, then nops for the wrong-path fetches
    task automatic end_program(int p);
        halt_pc[p] = prog_len[p] * 4;
        add_word(p, i_word(op_beq, 5'd0, 5'd0, 16'hffff));
        repeat (4) add_word(p, '0);
    endtask

    task automatic build_table();
        word_t       a;
        word_t       b;
        word_t       r3;
        word_t       r4;
        word_t       r5;
        logic [15:0] i1;
        logic [15:0] i2;
        logic [15:0] i3;
        logic [15:0] i4;
        logic [4:0]  sh;
        for (int p = 0; p < N_PROG; p++) begin
            prog_len[p] = 0;
            exp_cnt[p]  = 0;
        end

        // Dependent chain through both forwarding paths
        a  = xorshift32();
        b  = xorshift32();
        i1 = rand16();
        load_const(0, 5'd1, a);
        load_const(0, 5'd2, b);
        add_word(0, r_word(fn_add, 5'd3, 5'd1, 5'd2, 5'd0));
        add_word(0, r_word(fn_sub, 5'd4, 5'd3, 5'd1, 5'd0));
        add_word(0, i_word(op_addi, 5'd5, 5'd4, i1));
        add_word(0, r_word(fn_and, 5'd6, 5'd3, 5'd5, 5'd0));
        add_word(0, r_word(fn_or, 5'd7, 5'd6, 5'd4, 5'd0));
        r3 = a + b;
        r4 = r3 - a;
        r5 = r4 + sext16(i1);
        add_expect(0, 5'd1, a);
        add_expect(0, 5'd2, b);
        add_expect(0, 5'd3, r3);
        add_expect(0, 5'd4, r4);
        add_expect(0, 5'd5, r5);
        add_expect(0, 5'd6, r3 & r5);
        add_expect(0, 5'd7, (r3 & r5) | r4);
        end_program(0);

        // Store, load and load-use stalls
        a = xorshift32();
        b = xorshift32();
        load_const(1, 5'd1, a);
        add_word(1, i_word(op_addi, 5'd2, 5'd0, 16'h0040));
        add_word(1, i_word(op_sw, 5'd1, 5'd2, 16'h0000));
        add_word(1, i_word(op_lw, 5'd3, 5'd2, 16'h0000));
        add_word(1, r_word(fn_add, 5'd4, 5'd3, 5'd3, 5'd0));
        load_const(1, 5'd5, b);
        add_word(1, i_word(op_sw, 5'd5, 5'd2, 16'h0004));
        add_word(1, i_word(op_lw, 5'd6, 5'd2, 16'h0004));
        add_word(1, r_word(fn_sub, 5'd7, 5'd6, 5'd1, 5'd0));
        add_expect(1, 5'd3, a);
        add_expect(1, 5'd4, a + a);
        add_expect(1, 5'd6, b);
        add_expect(1, 5'd7, b - a);
        end_program(1);

        // Taken beq over two writes, then a bne that falls through
        i1 = rand16();
        i2 = rand16();
        i3 = rand16();
        i4 = rand16();
        add_word(2, i_word(op_addi, 5'd1, 5'd0, i1));
        add_word(2, i_word(op_addi, 5'd2, 5'd0, i1));
        add_word(2, i_word(op_addi, 5'd3, 5'd0, i2));
        add_word(2, i_word(op_addi, 5'd4, 5'd0, i3));
        add_word(2, i_word(op_beq, 5'd2, 5'd1, 16'd2));
        add_word(2, i_word(op_addi, 5'd3, 5'd0, i2 ^ 16'h5a5a));
        add_word(2, i_word(op_addi, 5'd4, 5'd0, i3 ^ 16'h0f0f));
        add_word(2, i_word(op_bne, 5'd2, 5'd1, 16'd1));
        add_word(2, i_word(op_addi, 5'd5, 5'd0, i4));
        add_expect(2, 5'd1, sext16(i1));
        add_expect(2, 5'd3, sext16(i2));
        add_expect(2, 5'd4, sext16(i3));
        add_expect(2, 5'd5, sext16(i4));
        end_program(2);

        // Upper bits forced so zero and sign extension differ
        a  = xorshift32() | 32'h8000_0000;
        b  = xorshift32() & 32'h7fff_ffff;
        i1 = rand16() | 16'h8000;
        i2 = rand16() | 16'h8000;
        i3 = rand16() | 16'h8000;
        i4 = rand16() | 16'h8000;
        r3 = xorshift32();
        sh = r3[4:0];
        load_const(3, 5'd1, a);
        load_const(3, 5'd2, b);
        add_word(3, i_word(op_lui, 5'd3, 5'd0, i1));
        add_word(3, i_word(op_ori, 5'd4, 5'd1, i2));
        add_word(3, i_word(op_andi, 5'd5, 5'd1, i3));
        add_word(3, r_word(fn_slt, 5'd6, 5'd1, 5'd2, 5'd0));
        add_word(3, r_word(fn_slt, 5'd7, 5'd2, 5'd1, 5'd0));
        add_word(3, r_word(fn_sll, 5'd8, 5'd0, 5'd2, sh));
        add_word(3, i_word(op_addi, 5'd9, 5'd0, i4));
        add_expect(3, 5'd3, {i1, 16'h0000});
        add_expect(3, 5'd4, a | zext16(i2));
        add_expect(3, 5'd5, a & zext16(i3));
        add_expect(3, 5'd6, slt_ref(a, b));
        add_expect(3, 5'd7, slt_ref(b, a));
        add_expect(3, 5'd8, b << sh);
        add_expect(3, 5'd9, sext16(i4));
        end_program(3);

        // Writes to r0 are dropped and never forwarded
        a  = xorshift32();
        i1 = rand16() | 16'h0001;
        add_word(4, i_word(op_addi, 5'd0, 5'd0, i1));
        add_word(4, r_word(fn_add, 5'd1, 5'd0, 5'd0, 5'd0));
        load_const(4, 5'd2, a);
        add_word(4, r_word(fn_add, 5'd0, 5'd2, 5'd2, 5'd0));
        add_word(4, r_word(fn_or, 5'd3, 5'd0, 5'd2, 5'd0));
        add_expect(4, 5'd0, '0);
        add_expect(4, 5'd1, '0);
        add_expect(4, 5'd3, a);
        end_program(4);
    endtask

    //////////////////////////////
    // Checks
    task automatic check_reg(reg_addr_t r, word_t got, word_t expected);
        if (got !== expected) begin
            reg_errors = reg_errors + 1;
            $display("Mismatch o_dbg_data r%0d: got %h, expected %h", r, got, expected);
        end
    endtask

    task automatic check_pc(word_t got, word_t expected);
        if (got !== expected) begin
            pc_errors = pc_errors + 1;
            $display("Mismatch o_pc: got %h, expected %h", got, expected);
        end
    endtask

    task automatic run_program(int p);
        int n;
        reset = 1'b1;
        repeat (3) @(negedge clk);
        for (int i = 0; i < prog_len[p]; i++) begin
            imem_we   = 1'b1;
            imem_addr = i[IMEM_AW-1:0];
            imem_data = prog_words[p][i];
            @(negedge clk);
        end
        imem_we = 1'b0;
        reset   = 1'b0;
        while (pc !== halt_pc[p]) @(negedge clk);
        repeat (10) @(negedge clk);       // Drain pipeline and flush
        n = 0;
        while (pc !== halt_pc[p] && n < 4) begin   // Halt loop spans four fetches
            @(negedge clk);
            n = n + 1;
        end
        check_pc(pc, halt_pc[p]);
        for (int k = 0; k < exp_cnt[p]; k++) begin
            dbg_addr = exp_reg[p][k];
            @(negedge clk);
            check_reg(exp_reg[p][k], dbg_data, exp_val[p][k]);
        end
    endtask

    initial begin
        int total;
        int sva_errors;
        clk         = 1'b0;
        reset       = 1'b1;
        imem_we     = 1'b0;
        imem_addr   = '0;
        imem_data   = '0;
        dbg_addr    = '0;
        rng_state   = 32'd24955;
        cycle_count = 0;
        cycle_limit = 0;
        reg_errors  = 0;
        pc_errors   = 0;
        build_table();
        total = 0;
        for (int p = 0; p < N_PROG; p++) begin
            total = total + prog_len[p];
        end
        cycle_limit = total * 8 + 200;
        @(negedge clk);
        for (int p = 0; p < N_PROG; p++) begin
            run_program(p);
        end
        sva_errors = mips_pipeline_top_i.pipe_control_i.mips_pipeline_sva_i.assert_failures;
        $display("Register errors: %0d, PC errors: %0d, assertion errors: %0d",
                 reg_errors, pc_errors, sva_errors);
        if (reg_errors + pc_errors + sva_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
logic/mips_isa_pkg.sv
logic/mips_pipe_pkg.sv
logic/pipe_ifs.sv
logic/stage_fetch.sv
logic/pipe_control.sv
logic/stage_decode.sv
logic/stage_execute.sv
logic/stage_memory.sv
logic/mips_pipeline_top.sv
dv/mips_pipeline_sva.sv
dv/mips_pipeline_tb.sv

// File: logic/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    // Primary opcode field
    typedef enum logic [5:0] {
        op_rtype = 6'b000000,
        op_beq   = 6'b000100,
        op_bne   = 6'b000101,
        op_addi  = 6'b001000,
        op_andi  = 6'b001100,
        op_ori   = 6'b001101,
        op_lui   = 6'b001111,
        op_lw    = 6'b100011,
        op_sw    = 6'b101011
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        fn_sll = 6'b000000,
        fn_add = 6'b100000,
        fn_sub = 6'b100010,
        fn_and = 6'b100100,
        fn_or  = 6'b100101,
        fn_slt = 6'b101010
    } funct_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sll,
        alu_lui     // Immediate moved to upper half
    } alu_op_e;

    typedef struct packed {
        opcode_e    opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    // Same word seen as register or immediate format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

endpackage

`default_nettype wire

// File: logic/mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;

    import mips_isa_pkg::*;

    // Used in execute
    typedef struct packed {
        logic    reg_dst;        // Write rd, else rt
        logic    alu_src_imm;    // B operand from immediate
        logic    alu_src_shamt;  // A operand from shamt
        alu_op_e alu_op;
    } ctrl_ex_t;

    // Used in memory
    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic branch;
        logic branch_ne;         // bne instead of beq
    } ctrl_mem_t;

    // Used in write-back
    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
    } ctrl_wb_t;

    // Source of an execute operand
    typedef enum logic [1:0] {
        fwd_none,
        fwd_from_mem,
        fwd_from_wb
    } fwd_sel_e;

endpackage

`default_nettype wire

// File: logic/mips_pipeline_top.sv
`default_nettype none

module mips_pipeline_top import mips_isa_pkg::*, mips_pipe_pkg::*; #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
    input  word_t                         i_imem_data,
    input  reg_addr_t                     i_dbg_addr,
    output word_t                         o_dbg_data,
    output word_t                         o_pc
);

    hazard_if hz_bus ();
    wb_if     wb_bus ();

    // Fetch and control
    instr_u     if_instr;
    word_t      if_pc_next;
    ctrl_ex_t   dec_ctrl_ex;
    ctrl_mem_t  dec_ctrl_mem;
    ctrl_wb_t   dec_ctrl_wb;
    logic       stall;
    logic       flush;

    // ID/EX
    ctrl_ex_t   id_ctrl_ex;
    ctrl_mem_t  id_ctrl_mem;
    ctrl_wb_t   id_ctrl_wb;
    word_t      id_pc_next;
    word_t      id_rs_data;
    word_t      id_rt_data;
    word_t      id_imm;
    reg_addr_t  id_rs;
    reg_addr_t  id_rt;
    reg_addr_t  id_rd;
    logic [4:0] id_shamt;

    // EX/MEM
    ctrl_mem_t  ex_ctrl_mem;
    ctrl_wb_t   ex_ctrl_wb;
    word_t      ex_alu_result;
    word_t      ex_store_data;
    word_t      ex_branch_target;
    logic       ex_alu_zero;
    reg_addr_t  ex_dest;

    stage_fetch #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) stage_fetch_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .i_stall     (stall),
        .i_flush     (flush),
        .branch      (wb_bus),
        .o_instr     (if_instr),
        .o_pc_next   (if_pc_next),
        .o_pc        (o_pc)
    );

    pipe_control pipe_control_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_instr    (if_instr),
        .i_taken    (wb_bus.taken),
        .o_ctrl_ex  (dec_ctrl_ex),
        .o_ctrl_mem (dec_ctrl_mem),
        .o_ctrl_wb  (dec_ctrl_wb),
        .o_stall    (stall),
        .o_flush    (flush),
        .hz         (hz_bus)
    );

    stage_decode stage_decode_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_instr    (if_instr),
        .i_pc_next  (if_pc_next),
        .i_ctrl_ex  (dec_ctrl_ex),
        .i_ctrl_mem (dec_ctrl_mem),
        .i_ctrl_wb  (dec_ctrl_wb),
        .i_bubble   (stall),
        .i_flush    (flush),
        .wb         (wb_bus),
        .i_dbg_addr (i_dbg_addr),
        .o_dbg_data (o_dbg_data),
        .o_ctrl_ex  (id_ctrl_ex),
        .o_ctrl_mem (id_ctrl_mem),
        .o_ctrl_wb  (id_ctrl_wb),
        .o_pc_next  (id_pc_next),
        .o_rs_data  (id_rs_data),
        .o_rt_data  (id_rt_data),
        .o_imm      (id_imm),
        .o_rs       (id_rs),
        .o_rt       (id_rt),
        .o_rd       (id_rd),
        .o_shamt    (id_shamt)
    );

    stage_execute stage_execute_i (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_ctrl_ex       (id_ctrl_ex),
        .i_ctrl_mem      (id_ctrl_mem),
        .i_ctrl_wb       (id_ctrl_wb),
        .i_pc_next       (id_pc_next),
        .i_rs_data       (id_rs_data),
        .i_rt_data       (id_rt_data),
        .i_imm           (id_imm),
        .i_rs            (id_rs),
        .i_rt            (id_rt),
        .i_rd            (id_rd),
        .i_shamt         (id_shamt),
        .i_flush         (flush),
        .hz              (hz_bus),
        .i_wb_data       (wb_bus.data),
        .o_ctrl_mem      (ex_ctrl_mem),
        .o_ctrl_wb       (ex_ctrl_wb),
        .o_alu_result    (ex_alu_result),
        .o_store_data    (ex_store_data),
        .o_branch_target (ex_branch_target),
        .o_alu_zero      (ex_alu_zero),
        .o_dest          (ex_dest)
    );

    stage_memory #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) stage_memory_i (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_ctrl_mem      (ex_ctrl_mem),
        .i_ctrl_wb       (ex_ctrl_wb),
        .i_alu_result    (ex_alu_result),
        .i_store_data    (ex_store_data),
        .i_branch_target (ex_branch_target),
        .i_alu_zero      (ex_alu_zero),
        .i_dest          (ex_dest),
        .hz              (hz_bus),
        .wb              (wb_bus)
    );

endmodule

`default_nettype wire

// File: logic/pipe_control.sv
`default_nettype none

module pipe_control import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic      i_clk,      // Sampled by the bound checker
    input  logic      i_reset,
    input  instr_u    i_instr,    // Instruction in decode
    input  logic      i_taken,
    output ctrl_ex_t  o_ctrl_ex,
    output ctrl_mem_t o_ctrl_mem,
    output ctrl_wb_t  o_ctrl_wb,
    output logic      o_stall,
    output logic      o_flush,
    hazard_if.ctrl    hz
);

    logic load_use;

    // EX/MEM is the younger producer, so it is checked first
    function automatic fwd_sel_e fwd_pick(reg_addr_t src);
        fwd_sel_e sel;
        sel = fwd_none;
        if (hz.mem_reg_write && hz.mem_dest != '0 && hz.mem_dest == src) begin
            sel = fwd_from_mem;
        end else if (hz.wb_reg_write && hz.wb_dest != '0 && hz.wb_dest == src) begin
            sel = fwd_from_wb;
        end
        return sel;
    endfunction

    //////////////////////////////
    // Main decoder
    always_comb begin
        o_ctrl_ex  = '0;
        o_ctrl_mem = '0;
        o_ctrl_wb  = '0;
        case (i_instr.r_fmt.opcode)
            op_rtype: begin
                o_ctrl_ex.reg_dst   = 1'b1;
                o_ctrl_wb.reg_write = 1'b1;
                case (i_instr.r_fmt.funct)
                    fn_add: o_ctrl_ex.alu_op = alu_add;
                    fn_sub: o_ctrl_ex.alu_op = alu_sub;
                    fn_and: o_ctrl_ex.alu_op = alu_and;
                    fn_or:  o_ctrl_ex.alu_op = alu_or;
                    fn_slt: o_ctrl_ex.alu_op = alu_slt;
                    fn_sll: begin
                        o_ctrl_ex.alu_op        = alu_sll;
                        o_ctrl_ex.alu_src_shamt = 1'b1;
                    end
                    default: o_ctrl_wb.reg_write = 1'b0;   // Unsupported funct
                endcase
            end
            op_addi, op_andi, op_ori, op_lui: begin
                o_ctrl_ex.alu_src_imm = 1'b1;
                o_ctrl_wb.reg_write   = 1'b1;
                case (i_instr.i_fmt.opcode)
                    op_andi: o_ctrl_ex.alu_op = alu_and;
                    op_ori:  o_ctrl_ex.alu_op = alu_or;
                    op_lui:  o_ctrl_ex.alu_op = alu_lui;
                    default: o_ctrl_ex.alu_op = alu_add;
                endcase
            end
            op_lw: begin
                o_ctrl_ex.alu_src_imm = 1'b1;
                o_ctrl_mem.mem_read   = 1'b1;
                o_ctrl_wb.reg_write   = 1'b1;
                o_ctrl_wb.mem_to_reg  = 1'b1;
            end
            op_sw: begin
                o_ctrl_ex.alu_src_imm = 1'b1;
                o_ctrl_mem.mem_write  = 1'b1;
            end
            op_beq, op_bne: begin
                o_ctrl_ex.alu_op     = alu_sub;   // Compare through zero flag
                o_ctrl_mem.branch    = 1'b1;
                o_ctrl_mem.branch_ne = (i_instr.r_fmt.opcode == op_bne);
            end
            default: ;
        endcase
    end

    //////////////////////////////
    // Load-use hazard
    always_comb begin
        load_use = 1'b0;
        if (hz.ex_mem_read && hz.ex_dest != '0 &&
            (hz.ex_dest == i_instr.r_fmt.rs || hz.ex_dest == i_instr.r_fmt.rt)) begin
            load_use = 1'b1;
        end
    end

    assign o_stall = load_use && !i_taken;   // Flushed load needs no stall
    assign o_flush = i_taken;

    always_comb begin
        hz.fwd_a = fwd_pick(hz.ex_rs);
        hz.fwd_b = fwd_pick(hz.ex_rt);
    end

endmodule

`default_nettype wire

// File: logic/pipe_ifs.sv
`default_nettype none

// Forwarding and load-use information gathered from the later stages
interface hazard_if import mips_isa_pkg::*, mips_pipe_pkg::*; ();

    reg_addr_t ex_rs;
    reg_addr_t ex_rt;
    logic      ex_mem_read;
    reg_addr_t ex_dest;
    logic      mem_reg_write;
    reg_addr_t mem_dest;
    logic      wb_reg_write;
    reg_addr_t wb_dest;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;

    modport ctrl (
        input  ex_rs, ex_rt, ex_mem_read, ex_dest,
        input  mem_reg_write, mem_dest, wb_reg_write, wb_dest,
        output fwd_a, fwd_b
    );
    modport ex (
        output ex_rs, ex_rt, ex_mem_read, ex_dest,
        input  fwd_a, fwd_b
    );
    modport mem (
        output mem_reg_write, mem_dest, wb_reg_write, wb_dest
    );

endinterface

// Register write-back plus the branch redirect, both sourced by memory
interface wb_if import mips_isa_pkg::*; ();

    logic      we;
    reg_addr_t dest;
    word_t     data;
    logic      taken;
    word_t     target;

    modport src (output we, dest, data, taken, target);
    modport rf  (input we, dest, data);
    modport pc  (input taken, target);

endinterface

`default_nettype wire

// File: logic/stage_decode.sv
`default_nettype none

module stage_decode import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,
    input  instr_u     i_instr,
    input  word_t      i_pc_next,
    input  ctrl_ex_t   i_ctrl_ex,
    input  ctrl_mem_t  i_ctrl_mem,
    input  ctrl_wb_t   i_ctrl_wb,
    input  logic       i_bubble,
    input  logic       i_flush,
    wb_if.rf           wb,
    input  reg_addr_t  i_dbg_addr,
    output word_t      o_dbg_data,
    output ctrl_ex_t   o_ctrl_ex,
    output ctrl_mem_t  o_ctrl_mem,
    output ctrl_wb_t   o_ctrl_wb,
    output word_t      o_pc_next,
    output word_t      o_rs_data,
    output word_t      o_rt_data,
    output word_t      o_imm,
    output reg_addr_t  o_rs,
    output reg_addr_t  o_rt,
    output reg_addr_t  o_rd,
    output logic [4:0] o_shamt
);

    word_t regs [32];
    word_t rs_val;
    word_t rt_val;
    word_t imm_ext;

    // Write-first read, r0 hardwired to zero
    function automatic word_t rf_read(reg_addr_t addr);
        word_t val;
        val = (addr == '0) ? '0 : regs[addr];
        if (wb.we && addr != '0 && wb.dest == addr) begin
            val = wb.data;
        end
        return val;
    endfunction

    always_ff @(posedge i_clk) begin
        if (wb.we && wb.dest != '0) begin
            regs[wb.dest] <= wb.data;
        end
    end

    always_comb begin
        rs_val = rf_read(i_instr.r_fmt.rs);
        rt_val = rf_read(i_instr.r_fmt.rt);
    end

    assign o_dbg_data = (i_dbg_addr == '0) ? '0 : regs[i_dbg_addr];

    // Logical immediates are zero extended
    always_comb begin
        case (i_instr.i_fmt.opcode)
            op_andi, op_ori: imm_ext = {16'h0000, i_instr.i_fmt.imm};
            default:         imm_ext = {{16{i_instr.i_fmt.imm[15]}}, i_instr.i_fmt.imm};
        endcase
    end

    //////////////////////////////
    // ID/EX register
    always_ff @(posedge i_clk) begin
        if (i_reset || i_bubble || i_flush) begin
            o_ctrl_ex  <= '0;
            o_ctrl_mem <= '0;
            o_ctrl_wb  <= '0;
        end else begin
            o_ctrl_ex  <= i_ctrl_ex;
            o_ctrl_mem <= i_ctrl_mem;
            o_ctrl_wb  <= i_ctrl_wb;
        end
    end

    always_ff @(posedge i_clk) begin
        o_pc_next <= i_pc_next;
        o_rs_data <= rs_val;
        o_rt_data <= rt_val;
        o_imm     <= imm_ext;
        o_rs      <= i_instr.r_fmt.rs;
        o_rt      <= i_instr.r_fmt.rt;
        o_rd      <= i_instr.r_fmt.rd;
        o_shamt   <= i_instr.r_fmt.shamt;
    end

endmodule

`default_nettype wire

// File: logic/stage_execute.sv
`default_nettype none

module stage_execute import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,
    input  ctrl_ex_t   i_ctrl_ex,
    input  ctrl_mem_t  i_ctrl_mem,
    input  ctrl_wb_t   i_ctrl_wb,
    input  word_t      i_pc_next,
    input  word_t      i_rs_data,
    input  word_t      i_rt_data,
    input  word_t      i_imm,
    input  reg_addr_t  i_rs,
    input  reg_addr_t  i_rt,
    input  reg_addr_t  i_rd,
    input  logic [4:0] i_shamt,
    input  logic       i_flush,
    hazard_if.ex       hz,
    input  word_t      i_wb_data,
    output ctrl_mem_t  o_ctrl_mem,
    output ctrl_wb_t   o_ctrl_wb,
    output word_t      o_alu_result,
    output word_t      o_store_data,
    output word_t      o_branch_target,
    output logic       o_alu_zero,
    output reg_addr_t  o_dest
);

    word_t     fwd_a_val;
    word_t     fwd_b_val;
    word_t     op_a;
    word_t     op_b;
    word_t     alu_out;
    reg_addr_t dest;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            fwd_from_mem: return mem_val;
            fwd_from_wb:  return wb_val;
            default:      return rf_val;
        endcase
    endfunction

    assign fwd_a_val = fwd_mux(hz.fwd_a, i_rs_data, o_alu_result, i_wb_data);
    assign fwd_b_val = fwd_mux(hz.fwd_b, i_rt_data, o_alu_result, i_wb_data);

    assign op_a = i_ctrl_ex.alu_src_shamt ? {27'd0, i_shamt} : fwd_a_val;
    assign op_b = i_ctrl_ex.alu_src_imm ? i_imm : fwd_b_val;
    assign dest = i_ctrl_ex.reg_dst ? i_rd : i_rt;

    // Seen by hazard detection and forwarding
    assign hz.ex_rs       = i_rs;
    assign hz.ex_rt       = i_rt;
    assign hz.ex_mem_read = i_ctrl_mem.mem_read;
    assign hz.ex_dest     = dest;

    //////////////////////////////
    // ALU
    always_comb begin
        case (i_ctrl_ex.alu_op)
            alu_sub: alu_out = op_a - op_b;
            alu_and: alu_out = op_a & op_b;
            alu_or:  alu_out = op_a | op_b;
            alu_slt: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_sll: alu_out = op_b << op_a[4:0];   // rt shifted by shamt
            alu_lui: alu_out = {op_b[15:0], 16'h0000};
            default: alu_out = op_a + op_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush) begin
            o_ctrl_mem <= '0;
            o_ctrl_wb  <= '0;
        end else begin
            o_ctrl_mem <= i_ctrl_mem;
            o_ctrl_wb  <= i_ctrl_wb;
        end
    end

    always_ff @(posedge i_clk) begin
        o_alu_result    <= alu_out;
        o_store_data    <= fwd_b_val;
        o_branch_target <= i_pc_next + {i_imm[29:0], 2'b00};
        o_alu_zero      <= (alu_out == '0);
        o_dest          <= dest;
    end

endmodule

`default_nettype wire

// File: logic/stage_fetch.sv
`default_nettype none

module stage_fetch import mips_isa_pkg::*; #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,   // Word index
    input  word_t                         i_imem_data,
    input  logic                          i_stall,
    input  logic                          i_flush,
    wb_if.pc                              branch,
    output instr_u                        o_instr,
    output word_t                         o_pc_next,
    output word_t                         o_pc
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    word_t  imem [IMEM_DEPTH];
    word_t  pc_plus4;
    instr_u fetched;

    assign pc_plus4 = o_pc + 32'd4;
    assign fetched  = imem[o_pc[IMEM_AW+1:2]];

    // Program load port
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pc <= '0;
        end else if (branch.taken) begin
            o_pc <= branch.target;   // Redirect wins over a stall
        end else if (!i_stall) begin
            o_pc <= pc_plus4;
        end
    end

    //////////////////////////////
    // IF/ID register
    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush) begin
            o_instr <= '0;           // sll r0 acts as a no-op
        end else if (!i_stall) begin
            o_instr <= fetched;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_pc_next <= pc_plus4;
        end
    end

endmodule

`default_nettype wire

// File: logic/stage_memory.sv
`default_nettype none

module stage_memory import mips_isa_pkg::*, mips_pipe_pkg::*; #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic      i_clk,
    input  logic      i_reset,
    input  ctrl_mem_t i_ctrl_mem,
    input  ctrl_wb_t  i_ctrl_wb,
    input  word_t     i_alu_result,    // Also the byte address
    input  word_t     i_store_data,
    input  word_t     i_branch_target,
    input  logic      i_alu_zero,
    input  reg_addr_t i_dest,
    hazard_if.mem     hz,
    wb_if.src         wb
);

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    word_t              dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] dmem_idx;
    word_t              load_data;
    ctrl_wb_t           wb_ctrl;
    word_t              wb_load;
    word_t              wb_alu;
    reg_addr_t          wb_dest;

    assign dmem_idx  = i_alu_result[DMEM_AW+1:2];
    assign load_data = i_ctrl_mem.mem_read ? dmem[dmem_idx] : '0;

    always_ff @(posedge i_clk) begin
        if (i_ctrl_mem.mem_write) begin
            dmem[dmem_idx] <= i_store_data;
        end
    end

    // Branch resolution
    assign wb.taken  = i_ctrl_mem.branch && (i_ctrl_mem.branch_ne ? !i_alu_zero : i_alu_zero);
    assign wb.target = i_branch_target;

    //////////////////////////////
    // MEM/WB register
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wb_ctrl <= '0;
        end else begin
            wb_ctrl <= i_ctrl_wb;
        end
    end

    always_ff @(posedge i_clk) begin
        wb_load <= load_data;
        wb_alu  <= i_alu_result;
        wb_dest <= i_dest;
    end

    assign wb.we   = wb_ctrl.reg_write;
    assign wb.dest = wb_dest;
    assign wb.data = wb_ctrl.mem_to_reg ? wb_load : wb_alu;

    assign hz.mem_reg_write = i_ctrl_wb.reg_write;
    assign hz.mem_dest      = i_dest;
    assign hz.wb_reg_write  = wb_ctrl.reg_write;
    assign hz.wb_dest       = wb_dest;

endmodule

`default_nettype wire
